// ==== hw/ex_pkg.sv ====
// Shared types for the execute stage and writeback register file
// ALU operator, vector mode and compare reduction enums
// Vector word union, multiplier controls, issue, forward and writeback structs

`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////
  // Operator and mode encodings
  //////////////////////////////////////////////////

  // ALU operators
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_LTU,
    ALU_GE,
    ALU_GEU,
    ALU_MIN,
    ALU_MINU,
    ALU_MAX,
    ALU_MAXU
  } ex_alu_op_e;

  // Operand split: one word, two halfwords or four bytes
  typedef enum logic [1:0] {
    VEC_W = 2'b00,
    VEC_H = 2'b01,
    VEC_B = 2'b10
  } ex_vec_mode_e;

  // Reduction of per-lane compare bits into the branch flag
  typedef enum logic [1:0] {
    CMP_FULL = 2'b00,
    CMP_ANY  = 2'b01,
    CMP_ALL  = 2'b10
  } ex_cmp_mode_e;

  //////////////////////////////////////////////////
  // Data and control bundles
  //////////////////////////////////////////////////

  // One operand word, read as word, halfwords or bytes
  typedef union packed {
    logic [31:0]      w;
    logic [1:0][15:0] h;
    logic [3:0][7:0]  b;
  } ex_word_u;

  // Multiplier controls
  typedef struct packed {
    logic       en;
    logic       mac_en;
    // Bit 0 signs A, bit 1 signs B
    logic [1:0] signed_mode;
    // Bit 0 picks high half of A, bit 1 high half of B
    logic [1:0] sel_subword;
  } ex_mult_cfg_t;

  // Execute inputs of one instruction
  typedef struct packed {
    ex_alu_op_e   alu_op;
    ex_vec_mode_e vec_mode;
    ex_cmp_mode_e cmp_mode;
    ex_word_u     op_a;
    ex_word_u     op_b;
    ex_word_u     op_c;
    ex_mult_cfg_t mult;
    logic         fwd_we;
    logic [4:0]   fwd_addr;
    logic         wb_we;
    logic [4:0]   wb_addr;
    logic         csr_access;
    logic [31:0]  csr_rdata;
  } ex_issue_t;

  // Same-cycle forward write port
  typedef struct packed {
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
  } ex_fwd_t;

  // Pass-through writeback port, filled later with load data
  typedef struct packed {
    logic       we;
    logic [4:0] addr;
  } ex_wb_t;

endpackage

`default_nettype wire

// ==== hw/ex_alu.sv ====
// Combinational ALU with word, halfword and byte lanes
// Add/sub, logic, shifts, compares, min/max per lane
// Branch flag from reduced lane compare bits

`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  ex_alu_op_e   operator_i,
  input  ex_word_u     operand_a_i,
  input  ex_word_u     operand_b_i,
  input  ex_vec_mode_e vec_mode_i,
  input  ex_cmp_mode_e cmp_mode_i,
  output ex_word_u     result_o,
  output logic         flag_o
);

  // Per-lane compare bits and the lanes active in this mode
  logic [3:0] lane_flag;
  logic [3:0] lane_en;

  //////////////////////////////////////////////////
  // Single lane datapath
  //////////////////////////////////////////////////

  // Operands arrive zero extended to 32 bits, lw is the lane width
  // Returns the compare bit on top of the masked lane result
  function automatic logic [32:0] lane_calc(
    input ex_alu_op_e  op,
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [5:0]  lw
  );
    logic [31:0] mask;
    logic [31:0] a_sx;
    logic [31:0] b_sx;
    logic [5:0]  lw_m1;
    logic [4:0]  shamt;
    logic        lt_s;
    logic        lt_u;
    logic        cmp;
    logic [31:0] res;
    mask  = (lw == 6'd32) ? 32'hffff_ffff : ((32'd1 << lw) - 32'd1);
    // Sign extension from the lane's top bit
    a_sx  = $signed(a << (6'd32 - lw)) >>> (6'd32 - lw);
    b_sx  = $signed(b << (6'd32 - lw)) >>> (6'd32 - lw);
    // Shift amount limited to the lane width
    lw_m1 = lw - 6'd1;
    shamt = b[4:0] & lw_m1[4:0];
    lt_s  = $signed(a_sx) < $signed(b_sx);
    lt_u  = a < b;
    cmp   = 1'b0;
    res   = '0;
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLL:  res = a << shamt;
      ALU_SRL:  res = a >> shamt;
      ALU_SRA:  res = $signed(a_sx) >>> shamt;
      // Compares give all ones or all zeros per lane
      ALU_SLT,
      ALU_LT:   cmp = lt_s;
      ALU_SLTU,
      ALU_LTU:  cmp = lt_u;
      ALU_EQ:   cmp = (a == b);
      ALU_NE:   cmp = (a != b);
      ALU_GE:   cmp = ~lt_s;
      ALU_GEU:  cmp = ~lt_u;
      ALU_MIN:  res = lt_s ? a : b;
      ALU_MINU: res = lt_u ? a : b;
      ALU_MAX:  res = lt_s ? b : a;
      ALU_MAXU: res = lt_u ? b : a;
      default:  res = '0;
    endcase
    if (cmp)
    begin
      res = '1;
    end
    return {cmp, res & mask};
  endfunction

  //////////////////////////////////////////////////
  // Lane split
  //////////////////////////////////////////////////

  always_comb
  begin : alu_lanes
    logic [32:0] lane_out;
    result_o  = '0;
    lane_flag = '0;
    lane_en   = '0;
    case (vec_mode_i)
      VEC_H:
      begin
        // Two halfwords, no carry between them
        for (int i = 0; i < 2; i++)
        begin
          lane_out = lane_calc(operator_i, {16'b0, operand_a_i.h[i]},
                               {16'b0, operand_b_i.h[i]}, 6'd16);
          result_o.h[i] = lane_out[15:0];
          lane_flag[i]  = lane_out[32];
          lane_en[i]    = 1'b1;
        end
      end
      VEC_B:
      begin
        for (int i = 0; i < 4; i++)
        begin
          lane_out = lane_calc(operator_i, {24'b0, operand_a_i.b[i]},
                               {24'b0, operand_b_i.b[i]}, 6'd8);
          result_o.b[i] = lane_out[7:0];
          lane_flag[i]  = lane_out[32];
          lane_en[i]    = 1'b1;
        end
      end
      default:
      begin
        // Full 32-bit word
        lane_out     = lane_calc(operator_i, operand_a_i.w, operand_b_i.w, 6'd32);
        result_o.w   = lane_out[31:0];
        lane_flag[0] = lane_out[32];
        lane_en[0]   = 1'b1;
      end
    endcase
  end

  // Flag reduction over active lanes only
  always_comb
  begin
    case (cmp_mode_i)
      CMP_ANY: flag_o = |(lane_flag & lane_en);
      CMP_ALL: flag_o = &(lane_flag | ~lane_en);
      default: flag_o = lane_flag[0];
    endcase
  end

  // Operator must be driven whenever the ALU output is consumed
  always_comb
  begin
    assert #0 (!$isunknown(operator_i))
      else $error("ex_alu: operator_i is unknown");
  end

endmodule

`default_nettype wire

// ==== hw/ex_mult.sv ====
// Combinational multiplier
// Word products, halfword products with signed modes and subword select
// Optional accumulate with operand C

`default_nettype none

module ex_mult
  import ex_pkg::*;
(
  input  ex_mult_cfg_t cfg_i,
  input  ex_vec_mode_e vec_mode_i,
  input  ex_word_u     op_a_i,
  input  ex_word_u     op_b_i,
  input  ex_word_u     mac_i,
  output ex_word_u     result_o
);

  // Halfword operands after subword select
  logic [15:0] half_a;
  logic [15:0] half_b;

  // Halfwords extended to 32 bits per signed mode
  logic [31:0] ext_a;
  logic [31:0] ext_b;

  // Candidate products
  logic [31:0] prod_w;
  logic [31:0] prod_h;
  logic [31:0] prod;

  //////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////

  // Subword select picks the high or low half of each operand
  assign half_a = cfg_i.sel_subword[0] ? op_a_i.h[1] : op_a_i.h[0];
  assign half_b = cfg_i.sel_subword[1] ? op_b_i.h[1] : op_b_i.h[0];

  // Sign or zero extension
  assign ext_a = cfg_i.signed_mode[0] ? {{16{half_a[15]}}, half_a} : {16'b0, half_a};
  assign ext_b = cfg_i.signed_mode[1] ? {{16{half_b[15]}}, half_b} : {16'b0, half_b};

  //////////////////////////////////////////////////
  // Products
  //////////////////////////////////////////////////

  // Low word of A*B is the same for signed and unsigned inputs
  assign prod_w = op_a_i.w * op_b_i.w;

  // 16x16 product fits in 32 bits once extended
  assign prod_h = ext_a * ext_b;

  // Byte mode has no multiplier path, word path is reused
  assign prod = (vec_mode_i == VEC_H) ? prod_h : prod_w;

  // Accumulate and enable
  always_comb
  begin
    if (!cfg_i.en)
    begin
      result_o.w = '0;
    end
    else if (cfg_i.mac_en)
    begin
      result_o.w = prod + mac_i.w;
    end
    else
    begin
      result_o.w = prod;
    end
  end

  // Byte-lane multiply is not supported by decode
  always_comb
  begin
    assert #0 (!(cfg_i.en === 1'b1 && vec_mode_i === VEC_B))
      else $error("ex_mult: multiply enabled in byte vector mode");
  end

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
// Execute stage with ALU and multiplier
// Forward result select, branch outputs, stall control
// EX/WB pipeline register for the pass-through write port

`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Issue bundle from decode
  input  ex_issue_t   issue_i,
  input  logic        issue_valid_i,

  // Stall sources
  input  logic        lsu_ready_i,
  input  logic        wb_ready_i,
  output logic        ex_ready_o,

  // Same-cycle forward and registered writeback
  output ex_fwd_t     fwd_o,
  output ex_wb_t      wb_o,

  // Branch outputs
  output logic        branch_decision_o,
  output logic [31:0] jump_target_o
);

  // Datapath results
  ex_word_u alu_result;
  logic     alu_flag;
  ex_word_u mult_result;

  // Issue taken this cycle
  logic     accept;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  assign ex_ready_o = lsu_ready_i & wb_ready_i;
  assign accept     = issue_valid_i & ex_ready_o;

  //////////////////////////////////////////////////
  // ALU and multiplier
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i  (issue_i.alu_op),
    .operand_a_i (issue_i.op_a),
    .operand_b_i (issue_i.op_b),
    .vec_mode_i  (issue_i.vec_mode),
    .cmp_mode_i  (issue_i.cmp_mode),
    .result_o    (alu_result),
    .flag_o      (alu_flag)
  );

  // Operand C doubles as the accumulator input
  ex_mult mult_i (
    .cfg_i      (issue_i.mult),
    .vec_mode_i (issue_i.vec_mode),
    .op_a_i     (issue_i.op_a),
    .op_b_i     (issue_i.op_b),
    .mac_i      (issue_i.op_c),
    .result_o   (mult_result)
  );

  //////////////////////////////////////////////////
  // Forward port
  //////////////////////////////////////////////////

  // CSR data over multiplier over ALU
  always_comb
  begin
    fwd_o.we   = issue_i.fwd_we & accept;
    fwd_o.addr = issue_i.fwd_addr;
    if (issue_i.csr_access)
    begin
      fwd_o.data = issue_i.csr_rdata;
    end
    else if (issue_i.mult.en)
    begin
      fwd_o.data = mult_result.w;
    end
    else
    begin
      fwd_o.data = alu_result.w;
    end
  end

  // Branch taken when the reduced flag is set
  assign branch_decision_o = alu_flag;
  assign jump_target_o     = issue_i.op_c.w;

  //////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_o <= '0;
    end
    else if (accept)
    begin
      wb_o.we   <= issue_i.wb_we;
      wb_o.addr <= issue_i.wb_addr;
    end
    else if (wb_ready_i)
    begin
      // Nothing new arrives so the slot is flushed
      wb_o.we <= 1'b0;
    end
  end

  // A stalled issue stays valid and unchanged until it is taken
  issue_hold_until_accept : assert property (
    @(posedge clk) disable iff (!rst_n)
    (issue_valid_i && !ex_ready_o) |=> (issue_valid_i && $stable(issue_i))
  ) else $error("ex_stage: issue_i changed or dropped while stalled");

endmodule

`default_nettype wire

// ==== hw/ex_wb_regfile.sv ====
// 32-entry register file behind the execute stage
// Forward write port and writeback write port, forward wins on conflict
// One combinational read port, register 0 reads zero

`default_nettype none

module ex_wb_regfile
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Write ports
  input  ex_fwd_t     fwd_i,
  input  ex_wb_t      wb_i,
  input  logic [31:0] wb_rdata_i,
  output logic        wb_ready_o,

  // Read port
  input  logic [4:0]  raddr_i,
  output logic [31:0] rdata_o
);

  // Register storage, cleared so every register reads 0 after reset
  logic [31:0] regs [32];

  //////////////////////////////////////////////////
  // Write ports
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      // Load data first
      if (wb_i.we && (wb_i.addr != 5'd0))
      begin
        regs[wb_i.addr] <= wb_rdata_i;
      end
      // Forward write last, so it wins a same-register conflict
      if (fwd_i.we && (fwd_i.addr != 5'd0))
      begin
        regs[fwd_i.addr] <= fwd_i.data;
      end
    end
  end

  // Writeback never stalls here
  assign wb_ready_o = 1'b1;

  // Combinational read, x0 hardwired to zero
  assign rdata_o = (raddr_i == 5'd0) ? 32'd0 : regs[raddr_i];

endmodule

`default_nettype wire

// ==== hw/ex_top.sv ====
// Top level: execute stage and writeback register file

`default_nettype none

module ex_top
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Issue side
  input  ex_issue_t   issue_i,
  input  logic        issue_valid_i,
  output logic        ex_ready_o,

  // LSU stand-in
  input  logic        lsu_ready_i,
  input  logic [31:0] lsu_rdata_i,

  // Forward, writeback and branch outputs
  output ex_fwd_t     fwd_o,
  output ex_wb_t      wb_o,
  output logic        branch_decision_o,
  output logic [31:0] jump_target_o,

  // Register file read port
  input  logic [4:0]  rf_raddr_i,
  output logic [31:0] rf_rdata_o
);

  // Writeback back-pressure from the register file
  logic wb_ready;

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue_i),
    .issue_valid_i     (issue_valid_i),
    .lsu_ready_i       (lsu_ready_i),
    .wb_ready_i        (wb_ready),
    .ex_ready_o        (ex_ready_o),
    .fwd_o             (fwd_o),
    .wb_o              (wb_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o)
  );

  // Forward and writeback ports feed the same storage
  ex_wb_regfile regfile_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fwd_i      (fwd_o),
    .wb_i       (wb_o),
    .wb_rdata_i (lsu_rdata_i),
    .wb_ready_o (wb_ready),
    .raddr_i    (rf_raddr_i),
    .rdata_o    (rf_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_ex_ref.svh ====
// Reference model for the execute stage testbench
// Lane-wise ALU with flag reduction, multiplier with accumulate
// Forward port value with CSR over multiplier over ALU

`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

  //////////////////////////////////////////////////
  // ALU reference
  //////////////////////////////////////////////////

  function automatic ex_word_u ref_alu(
    input  ex_alu_op_e   op,
    input  ex_word_u     a,
    input  ex_word_u     b,
    input  ex_vec_mode_e vm,
    input  ex_cmp_mode_e cm,
    output logic         flag
  );
    int          lanes;
    int          lw;
    int          sh;
    logic [63:0] mask;
    logic [63:0] sbit;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] r;
    logic        lt_s;
    logic        lt_u;
    logic        hit;
    logic        first_hit;
    logic        any_hit;
    logic        all_hit;
    ex_word_u    res;
    case (vm)
      VEC_H:   lanes = 2;
      VEC_B:   lanes = 4;
      default: lanes = 1;
    endcase
    lw        = 32 / lanes;
    mask      = (64'd1 << lw) - 64'd1;
    sbit      = 64'd1 << (lw - 1);
    res       = '0;
    first_hit = 1'b0;
    any_hit   = 1'b0;
    all_hit   = 1'b1;
    for (int i = 0; i < lanes; i++)
    begin
      x    = ({32'b0, a.w} >> (i * lw)) & mask;
      y    = ({32'b0, b.w} >> (i * lw)) & mask;
      sh   = int'(y[4:0]) % lw;
      lt_u = x < y;
      // Flipping the sign bit turns signed order into unsigned order
      lt_s = (x ^ sbit) < (y ^ sbit);
      hit  = 1'b0;
      r    = '0;
      case (op)
        ALU_ADD:  r = x + y;
        ALU_SUB:  r = x - y;
        ALU_AND:  r = x & y;
        ALU_OR:   r = x | y;
        ALU_XOR:  r = x ^ y;
        ALU_SLL:  r = x << sh;
        ALU_SRL:  r = x >> sh;
        // Logical shift, then fill the vacated top bits with the sign
        ALU_SRA:  r = (x >> sh) | (((x & sbit) != 0) ? (mask << (lw - sh)) : 64'd0);
        ALU_SLT,
        ALU_LT:   hit = lt_s;
        ALU_SLTU,
        ALU_LTU:  hit = lt_u;
        ALU_EQ:   hit = (x == y);
        ALU_NE:   hit = (x != y);
        ALU_GE:   hit = !lt_s;
        ALU_GEU:  hit = !lt_u;
        ALU_MIN:  r = lt_s ? x : y;
        ALU_MINU: r = lt_u ? x : y;
        ALU_MAX:  r = lt_s ? y : x;
        ALU_MAXU: r = lt_u ? y : x;
        default:  r = '0;
      endcase
      if (hit)
      begin
        r = mask;
      end
      res.w = res.w | 32'((r & mask) << (i * lw));
      if (i == 0)
      begin
        first_hit = hit;
      end
      any_hit = any_hit | hit;
      all_hit = all_hit & hit;
    end
    case (cm)
      CMP_ANY: flag = any_hit;
      CMP_ALL: flag = all_hit;
      default: flag = first_hit;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Multiplier and forward references
  //////////////////////////////////////////////////

  function automatic ex_word_u ref_mult(
    input ex_mult_cfg_t cfg,
    input ex_vec_mode_e vm,
    input ex_word_u     a,
    input ex_word_u     b,
    input ex_word_u     c
  );
    logic [15:0] ha;
    logic [15:0] hb;
    logic [63:0] xa;
    logic [63:0] xb;
    ex_word_u    res;
    if (!cfg.en)
    begin
      return '0;
    end
    if (vm == VEC_H)
    begin
      ha    = cfg.sel_subword[0] ? a.w[31:16] : a.w[15:0];
      hb    = cfg.sel_subword[1] ? b.w[31:16] : b.w[15:0];
      xa    = cfg.signed_mode[0] ? 64'($signed(ha)) : 64'(ha);
      xb    = cfg.signed_mode[1] ? 64'($signed(hb)) : 64'(hb);
      res.w = 32'(xa * xb);
    end
    else
    begin
      res.w = 32'({32'b0, a.w} * {32'b0, b.w});
    end
    if (cfg.mac_en)
    begin
      res.w = res.w + c.w;
    end
    return res;
  endfunction

  // Expected forward port for one issue
  function automatic ex_fwd_t ref_fwd(input ex_issue_t it, input logic accept);
    logic     flag;
    ex_word_u alu_res;
    ex_word_u mult_res;
    ex_fwd_t  f;
    alu_res  = ref_alu(it.alu_op, it.op_a, it.op_b, it.vec_mode, it.cmp_mode, flag);
    mult_res = ref_mult(it.mult, it.vec_mode, it.op_a, it.op_b, it.op_c);
    f.we     = it.fwd_we & accept;
    f.addr   = it.fwd_addr;
    if (it.csr_access)
      f.data = it.csr_rdata;
    else if (it.mult.en)
      f.data = mult_res.w;
    else
      f.data = alu_res.w;
    return f;
  endfunction

`endif

// ==== tb/tb_ex_top.sv ====
// Testbench for the execute stage top level
// Clock, reset, issue stimulus, per-cycle compare process
// Register file model, typed compare tasks and timeout

`default_nettype none

module tb_ex_top
  import ex_pkg::*;
();

  // Issue counts per test phase
  localparam int N_RAND      = 300;
  localparam int N_CMP       = 72;
  localparam int N_MULT      = 64;
  localparam int N_CSR       = 24;
  localparam int N_STALL     = 100;
  localparam int N_RF        = 16;
  localparam int N_ISSUE     = N_RAND + N_CMP + N_MULT + N_CSR + N_STALL + N_RF;
  localparam int CYCLE_LIMIT = N_ISSUE * 4 + 100;

  logic        clk;
  logic        rst_n;
  ex_issue_t   issue;
  logic        issue_valid;
  logic        lsu_ready;
  logic [31:0] lsu_rdata;
  logic [4:0]  rf_raddr;
  logic        ex_ready;
  ex_fwd_t     fwd;
  ex_wb_t      wb;
  logic        branch_decision;
  logic [31:0] jump_target;
  logic [31:0] rf_rdata;

  integer      seed;
  logic        stall_en;
  int          err_count;
  int          check_count;
  int          cycle_count;

  // Expected register contents and expected EX/WB register
  logic [31:0] reg_model [32];
  ex_wb_t      exp_wb;

  ex_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue),
    .issue_valid_i     (issue_valid),
    .ex_ready_o        (ex_ready),
    .lsu_ready_i       (lsu_ready),
    .lsu_rdata_i       (lsu_rdata),
    .fwd_o             (fwd),
    .wb_o              (wb),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .rf_raddr_i        (rf_raddr),
    .rf_rdata_o        (rf_rdata)
  );

  `include "tb_ex_ref.svh"

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input ex_word_u exp, input ex_word_u act);
    check_count = check_count + 1;
    if (act !== exp)
    begin
      err_count = err_count + 1;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp.w, act.w);
    end
  endtask

  task automatic check_fwd(input string name, input ex_fwd_t exp, input ex_fwd_t act);
    check_count = check_count + 1;
    if (act !== exp)
    begin
      err_count = err_count + 1;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_wb(input string name, input ex_wb_t exp, input ex_wb_t act);
    check_count = check_count + 1;
    if (act !== exp)
    begin
      err_count = err_count + 1;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count = check_count + 1;
    if (act !== exp)
    begin
      err_count = err_count + 1;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // LSU readiness is random only in the stall phase
  function automatic logic pick_ready();
    if (stall_en)
      return 1'(rand_below(2));
    return 1'b1;
  endfunction

  // Random ALU-only issue
  function automatic ex_issue_t rand_issue();
    ex_issue_t it;
    it.alu_op     = ex_alu_op_e'(5'(rand_below(20)));
    it.vec_mode   = ex_vec_mode_e'(2'(rand_below(3)));
    it.cmp_mode   = ex_cmp_mode_e'(2'(rand_below(3)));
    it.op_a.w     = $random(seed);
    it.op_b.w     = $random(seed);
    it.op_c.w     = $random(seed);
    it.mult       = '0;
    it.fwd_we     = 1'(rand_below(2));
    it.fwd_addr   = 5'(rand_below(32));
    it.wb_we      = 1'(rand_below(2));
    it.wb_addr    = 5'(rand_below(32));
    it.csr_access = 1'b0;
    it.csr_rdata  = $random(seed);
    return it;
  endfunction

  // Present one issue and hold it until it is accepted
  task automatic send(input ex_issue_t it);
    logic done;
    issue       <= it;
    issue_valid <= 1'b1;
    lsu_ready   <= pick_ready();
    lsu_rdata   <= $random(seed);
    rf_raddr    <= 5'(rand_below(32));
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      if (issue_valid && ex_ready)
        done = 1'b1;
      else
      begin
        lsu_ready <= pick_ready();
        lsu_rdata <= $random(seed);
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      issue_valid <= 1'b0;
      lsu_ready   <= pick_ready();
      lsu_rdata   <= $random(seed);
      rf_raddr    <= 5'(rand_below(32));
      @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare process and register model
  //////////////////////////////////////////////////

  // Inputs change on the rising edge, so outputs are checked on the falling edge
  always @(negedge clk)
  begin : compare
    logic     accept;
    logic     flag;
    ex_word_u alu_res;
    ex_fwd_t  exp_fwd;
    if (!rst_n)
    begin
      exp_wb = '0;
      for (int i = 0; i < 32; i++)
        reg_model[i] = '0;
    end
    else
    begin
      accept  = issue_valid & lsu_ready;
      exp_fwd = ref_fwd(issue, accept);
      alu_res = ref_alu(issue.alu_op, issue.op_a, issue.op_b, issue.vec_mode,
                        issue.cmp_mode, flag);
      check_bit("ex_ready_o", lsu_ready, ex_ready);
      check_fwd("fwd_o", exp_fwd, fwd);
      check_bit("branch_decision_o", flag, branch_decision);
      check_word("jump_target_o", issue.op_c, jump_target);
      check_wb("wb_o", exp_wb, wb);
      check_word("rf_rdata_o", reg_model[rf_raddr], rf_rdata);
      // Writes that land at the next edge with the forward write applied last
      if (exp_wb.we && exp_wb.addr != 5'd0)
        reg_model[exp_wb.addr] = lsu_rdata;
      if (exp_fwd.we && exp_fwd.addr != 5'd0)
        reg_model[exp_fwd.addr] = exp_fwd.data;
      // EX/WB register loads on acceptance, otherwise flushes
      if (accept)
      begin
        exp_wb.we   = issue.wb_we;
        exp_wb.addr = issue.wb_addr;
      end
      else
        exp_wb.we = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Clock and timeout
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks: %0d, errors: %0d", check_count, err_count);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin : main
    ex_issue_t it;
    int        eq_pick;
    seed        = 32'h0d8e_7d4d;
    err_count   = 0;
    check_count = 0;
    cycle_count = 0;
    stall_en    = 1'b0;
    rst_n       = 1'b0;
    issue       = '0;
    issue_valid = 1'b0;
    lsu_ready   = 1'b1;
    lsu_rdata   = '0;
    rf_raddr    = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Every ALU operator in every vector mode with random operands
    for (int i = 0; i < N_RAND; i++)
    begin
      it          = rand_issue();
      it.alu_op   = ex_alu_op_e'(5'(i % 20));
      it.vec_mode = ex_vec_mode_e'(2'((i / 20) % 3));
      send(it);
    end

    // Every compare operator under every vector and reduction mode
    for (int op = int'(ALU_SLT); op <= int'(ALU_GEU); op++)
      for (int v = 0; v < 3; v++)
        for (int c = 0; c < 3; c++)
        begin
          it          = rand_issue();
          it.alu_op   = ex_alu_op_e'(5'(op));
          it.vec_mode = ex_vec_mode_e'(2'(v));
          it.cmp_mode = ex_cmp_mode_e'(2'(c));
          // Equal low lanes or equal words now and then for EQ, GE and ALL
          eq_pick = rand_below(3);
          if (eq_pick == 0)
            it.op_b.h[0] = it.op_a.h[0];
          else if (eq_pick == 1)
            it.op_b.w = it.op_a.w;
          send(it);
        end

    // Multiplier modes, subword selects and accumulate
    for (int v = 0; v < 2; v++)
      for (int sm = 0; sm < 4; sm++)
        for (int sel = 0; sel < 4; sel++)
          for (int mac = 0; mac < 2; mac++)
          begin
            it                  = rand_issue();
            it.vec_mode         = (v == 1) ? VEC_H : VEC_W;
            it.mult.en          = 1'b1;
            it.mult.mac_en      = 1'(mac);
            it.mult.signed_mode = 2'(sm);
            it.mult.sel_subword = 2'(sel);
            send(it);
          end

    // Forward priority of CSR over multiplier over ALU
    for (int i = 0; i < N_CSR; i++)
    begin
      it                  = rand_issue();
      it.vec_mode         = (i % 4 < 2) ? VEC_W : VEC_H;
      it.csr_access       = (i % 3 != 0);
      it.mult.en          = 1'(i % 2);
      it.mult.mac_en      = 1'(rand_below(2));
      it.mult.signed_mode = 2'(rand_below(4));
      it.mult.sel_subword = 2'(rand_below(4));
      send(it);
    end

    // Back-pressure with gaps between issues
    stall_en = 1'b1;
    for (int i = 0; i < N_STALL; i++)
    begin
      send(rand_issue());
      if (rand_below(2) == 0)
        idle(1);
    end
    stall_en = 1'b0;

    // Load then forward to the same register so both land on one edge
    for (int i = 0; i < N_RF / 2; i++)
    begin
      it         = rand_issue();
      it.wb_we   = 1'b1;
      it.wb_addr = 5'((i * 9) % 32);
      it.fwd_we  = 1'b0;
      send(it);
      it          = rand_issue();
      it.fwd_we   = 1'b1;
      it.fwd_addr = 5'((i * 9) % 32);
      it.wb_we    = 1'b0;
      send(it);
    end
    idle(2);

    // Read back every register
    for (int i = 0; i < 32; i++)
    begin
      issue_valid <= 1'b0;
      lsu_ready   <= 1'b1;
      rf_raddr    <= 5'(i);
      @(posedge clk);
    end
    @(posedge clk);

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tb
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_stage.sv
hw/ex_wb_regfile.sv
hw/ex_top.sv
tb/tb_ex_top.sv
